//--- logic/axil_region_pkg.sv
package axil_region_pkg;

	//////////////////////////////////////////////////
	// Bus geometry
	//////////////////////////////////////////////////

	// Byte address and fixed AXI-lite data width
	localparam int ADDR_WIDTH = 5;
	localparam int DATA_WIDTH = 32;

	// Register file size and word index width
	localparam int NREGS = 4;
	localparam int IDX_WIDTH = $clog2(NREGS);

	// Byte offset bits inside one word, ignored by decode
	localparam int ADDR_LSB = $clog2(DATA_WIDTH / 8);

	// Top address bit splits registers from the error region
	localparam int SEL_BIT = ADDR_WIDTH - 1;

	// Response codes
	localparam logic [1:0] RESP_OKAY = 2'b00;
	localparam logic [1:0] RESP_DECERR = 2'b11;

	//////////////////////////////////////////////////
	// Channel payloads
	//////////////////////////////////////////////////

	typedef struct packed {
		logic [ADDR_WIDTH-1:0] addr;
	} axil_aw_t;

	typedef struct packed {
		logic [DATA_WIDTH-1:0]   data;
		logic [DATA_WIDTH/8-1:0] strb;
	} axil_w_t;

	typedef struct packed {
		logic [ADDR_WIDTH-1:0] addr;
	} axil_ar_t;

	typedef struct packed {
		logic [DATA_WIDTH-1:0] data;
		logic [1:0]            resp;
	} axil_r_t;

endpackage

//--- logic/axil_skid.sv
`timescale 1ns/1ps

module axil_skid #(
	parameter type T = logic
) (
	input  logic S_AXI_ACLK,
	input  logic i_reset,
	// Upstream side
	input  logic i_valid,
	output logic o_ready,
	input  T     i_data,
	// Downstream side
	output logic o_valid,
	input  logic i_ready,
	output T     o_data
);

	// Holding register for one stalled item
	logic r_valid;
	T     r_data;

	//////////////////////////////////////////////////
	// Holding register control
	//////////////////////////////////////////////////

	always_ff @(posedge S_AXI_ACLK) begin
		if (i_reset) begin
			r_valid <= 1'b0;
		end else if (i_valid && o_ready && !i_ready) begin
			// Item accepted upstream but stalled downstream
			r_valid <= 1'b1;
		end else if (i_ready) begin
			// Held item drains first
			r_valid <= 1'b0;
		end
	end

	// Payload follows the input while the holding slot is free
	always_ff @(posedge S_AXI_ACLK) begin
		if (o_ready)
			r_data <= i_data;
	end

	//////////////////////////////////////////////////
	// Outputs
	//////////////////////////////////////////////////

	// Ready depends on internal state only
	assign o_ready = !r_valid;

	// Zero-cycle pass-through when nothing is held
	assign o_valid = i_valid || r_valid;
	assign o_data = r_valid ? r_data : i_data;

endmodule

//--- logic/axil_route.sv
`timescale 1ns/1ps

module axil_route (
	input  logic                             S_AXI_ACLK,
	input  logic                             i_reset,
	// Buffered requests
	input  logic                             i_awvalid,
	output logic                             o_awready,
	input  axil_region_pkg::axil_aw_t        i_aw,
	input  logic                             i_wvalid,
	output logic                             o_wready,
	input  axil_region_pkg::axil_w_t         i_w,
	input  logic                             i_arvalid,
	output logic                             o_arready,
	input  axil_region_pkg::axil_ar_t        i_ar,
	// Register target
	output logic                             o_reg_wr,
	output logic [axil_region_pkg::IDX_WIDTH-1:0]  o_reg_wr_idx,
	output axil_region_pkg::axil_w_t         o_reg_w,
	output logic                             o_reg_rd,
	output logic [axil_region_pkg::IDX_WIDTH-1:0]  o_reg_rd_idx,
	input  logic                             i_reg_bvalid,
	input  logic                             i_reg_rvalid,
	input  logic [axil_region_pkg::DATA_WIDTH-1:0] i_reg_rdata,
	// Error target
	output logic                             o_err_wr,
	output logic                             o_err_rd,
	input  logic                             i_err_bvalid,
	input  logic                             i_err_rvalid,
	// Merged responses
	output logic                             o_bvalid,
	input  logic                             i_bready,
	output logic [1:0]                       o_bresp,
	output logic                             o_rvalid,
	input  logic                             i_rready,
	output axil_region_pkg::axil_r_t         o_r,
	output logic                             o_back_b,
	output logic                             o_back_r
);

	import axil_region_pkg::*;

	logic wr_go, rd_go;
	logic wr_map, rd_map;
	// Owner of the outstanding response, set means error target
	logic r_b_err, r_r_err;

	//////////////////////////////////////////////////
	// Request side
	//////////////////////////////////////////////////

	// Address bit 4 clear selects the register file
	assign wr_map = !i_aw.addr[SEL_BIT];
	assign rd_map = !i_ar.addr[SEL_BIT];

	// One write in flight, AW and W taken together
	assign wr_go = i_awvalid && i_wvalid && !i_reg_bvalid && !i_err_bvalid;
	// One read in flight
	assign rd_go = i_arvalid && !i_reg_rvalid && !i_err_rvalid;

	assign o_awready = wr_go;
	assign o_wready = wr_go;
	assign o_arready = rd_go;

	// Steer strobes by decode
	assign o_reg_wr = wr_go && wr_map;
	assign o_err_wr = wr_go && !wr_map;
	assign o_reg_rd = rd_go && rd_map;
	assign o_err_rd = rd_go && !rd_map;

	// Word index, byte offset ignored
	assign o_reg_wr_idx = i_aw.addr[ADDR_LSB +: IDX_WIDTH];
	assign o_reg_rd_idx = i_ar.addr[ADDR_LSB +: IDX_WIDTH];
	assign o_reg_w = i_w;

	//////////////////////////////////////////////////
	// Response side
	//////////////////////////////////////////////////

	// Remember which target answers, stable until the next request
	always_ff @(posedge S_AXI_ACLK) begin
		if (i_reset) begin
			r_b_err <= 1'b0;
			r_r_err <= 1'b0;
		end else begin
			if (wr_go)
				r_b_err <= !wr_map;
			if (rd_go)
				r_r_err <= !rd_map;
		end
	end

	assign o_bvalid = i_reg_bvalid || i_err_bvalid;
	assign o_rvalid = i_reg_rvalid || i_err_rvalid;
	assign o_bresp = r_b_err ? RESP_DECERR : RESP_OKAY;

	// Error target returns zero data
	always_comb begin
		o_r.data = r_r_err ? '0 : i_reg_rdata;
		o_r.resp = r_r_err ? RESP_DECERR : RESP_OKAY;
	end

	// Handshake done, both targets see the acknowledge
	assign o_back_b = o_bvalid && i_bready;
	assign o_back_r = o_rvalid && i_rready;

endmodule

//--- logic/axil_regs.sv
`timescale 1ns/1ps

module axil_regs (
	input  logic                                   S_AXI_ACLK,
	input  logic                                   i_reset,
	// Write strobe with word index and payload
	input  logic                                   i_wr,
	input  logic [axil_region_pkg::IDX_WIDTH-1:0]  i_wr_idx,
	input  axil_region_pkg::axil_w_t               i_w,
	// Read strobe with word index
	input  logic                                   i_rd,
	input  logic [axil_region_pkg::IDX_WIDTH-1:0]  i_rd_idx,
	// Response acknowledges
	input  logic                                   i_back_b,
	input  logic                                   i_back_r,
	output logic                                   o_bvalid,
	output logic                                   o_rvalid,
	output logic [axil_region_pkg::DATA_WIDTH-1:0] o_rdata
);

	import axil_region_pkg::*;

	logic [DATA_WIDTH-1:0] r_mem [NREGS];

	//////////////////////////////////////////////////
	// Register file
	//////////////////////////////////////////////////

	always_ff @(posedge S_AXI_ACLK) begin
		if (i_reset) begin
			for (int i = 0; i < NREGS; i++)
				r_mem[i] <= '0;
		end else if (i_wr) begin
			// Only strobed bytes change
			for (int b = 0; b < DATA_WIDTH / 8; b++) begin
				if (i_w.strb[b])
					r_mem[i_wr_idx][8*b +: 8] <= i_w.data[8*b +: 8];
			end
		end
	end

	// Read data sampled with the strobe, held until accepted
	always_ff @(posedge S_AXI_ACLK) begin
		if (i_rd)
			o_rdata <= r_mem[i_rd_idx];
	end

	//////////////////////////////////////////////////
	// Response flags
	//////////////////////////////////////////////////

	always_ff @(posedge S_AXI_ACLK) begin
		if (i_reset) begin
			o_bvalid <= 1'b0;
			o_rvalid <= 1'b0;
		end else begin
			// Strobe wins over a stale acknowledge
			if (i_wr)
				o_bvalid <= 1'b1;
			else if (i_back_b)
				o_bvalid <= 1'b0;
			if (i_rd)
				o_rvalid <= 1'b1;
			else if (i_back_r)
				o_rvalid <= 1'b0;
		end
	end

endmodule

//--- logic/axil_empty.sv
`timescale 1ns/1ps

module axil_empty (
	input  logic S_AXI_ACLK,
	input  logic i_reset,
	// Request strobes from the router
	input  logic i_wr,
	input  logic i_rd,
	// Acknowledges once the master takes the response
	input  logic i_back_b,
	input  logic i_back_r,
	// Response pending flags
	output logic o_bvalid,
	output logic o_rvalid
);

	//////////////////////////////////////////////////
	// Write response flag
	//////////////////////////////////////////////////

	// Unmapped write completes with DECERR one cycle later
	always_ff @(posedge S_AXI_ACLK) begin
		if (i_reset)
			o_bvalid <= 1'b0;
		else if (i_wr)
			o_bvalid <= 1'b1;
		else if (i_back_b)
			o_bvalid <= 1'b0;
	end

	//////////////////////////////////////////////////
	// Read response flag
	//////////////////////////////////////////////////

	// No data held here
	// zero read data comes from the router merge
	always_ff @(posedge S_AXI_ACLK) begin
		if (i_reset)
			o_rvalid <= 1'b0;
		else if (i_rd)
			o_rvalid <= 1'b1;
		else if (i_back_r)
			o_rvalid <= 1'b0;
	end

endmodule

//--- logic/axil_region.sv
`timescale 1ns/1ps

module axil_region (
	input  logic                      S_AXI_ACLK,
	input  logic                      i_reset,
	// Write address
	input  logic                      i_awvalid,
	output logic                      o_awready,
	input  axil_region_pkg::axil_aw_t i_aw,
	// Write data
	input  logic                      i_wvalid,
	output logic                      o_wready,
	input  axil_region_pkg::axil_w_t  i_w,
	// Write response
	output logic                      o_bvalid,
	input  logic                      i_bready,
	output logic [1:0]                o_bresp,
	// Read address
	input  logic                      i_arvalid,
	output logic                      o_arready,
	input  axil_region_pkg::axil_ar_t i_ar,
	// Read response
	output logic                      o_rvalid,
	input  logic                      i_rready,
	output axil_region_pkg::axil_r_t  o_r
);

	import axil_region_pkg::*;

	// Buffered request channels
	logic     aw_valid, aw_ready, w_valid, w_ready, ar_valid, ar_ready;
	axil_aw_t aw_buf;
	axil_w_t  w_buf;
	axil_ar_t ar_buf;

	// Router to targets
	logic                  reg_wr, reg_rd, err_wr, err_rd;
	logic [IDX_WIDTH-1:0]  reg_wr_idx, reg_rd_idx;
	axil_w_t               reg_w;
	logic                  reg_bvalid, reg_rvalid, err_bvalid, err_rvalid;
	logic [DATA_WIDTH-1:0] reg_rdata;
	logic                  back_b, back_r;

	//////////////////////////////////////////////////
	// Request skid buffers
	//////////////////////////////////////////////////

	axil_skid #(.T(axil_aw_t)) awskid (
		.S_AXI_ACLK(S_AXI_ACLK), .i_reset(i_reset),
		.i_valid(i_awvalid), .o_ready(o_awready), .i_data(i_aw),
		.o_valid(aw_valid), .i_ready(aw_ready), .o_data(aw_buf));

	axil_skid #(.T(axil_w_t)) wskid (
		.S_AXI_ACLK(S_AXI_ACLK), .i_reset(i_reset),
		.i_valid(i_wvalid), .o_ready(o_wready), .i_data(i_w),
		.o_valid(w_valid), .i_ready(w_ready), .o_data(w_buf));

	axil_skid #(.T(axil_ar_t)) arskid (
		.S_AXI_ACLK(S_AXI_ACLK), .i_reset(i_reset),
		.i_valid(i_arvalid), .o_ready(o_arready), .i_data(i_ar),
		.o_valid(ar_valid), .i_ready(ar_ready), .o_data(ar_buf));

	//////////////////////////////////////////////////
	// Router and targets
	//////////////////////////////////////////////////

	axil_route route (
		.S_AXI_ACLK(S_AXI_ACLK), .i_reset(i_reset),
		.i_awvalid(aw_valid), .o_awready(aw_ready), .i_aw(aw_buf),
		.i_wvalid(w_valid), .o_wready(w_ready), .i_w(w_buf),
		.i_arvalid(ar_valid), .o_arready(ar_ready), .i_ar(ar_buf),
		.o_reg_wr(reg_wr), .o_reg_wr_idx(reg_wr_idx), .o_reg_w(reg_w),
		.o_reg_rd(reg_rd), .o_reg_rd_idx(reg_rd_idx),
		.i_reg_bvalid(reg_bvalid), .i_reg_rvalid(reg_rvalid), .i_reg_rdata(reg_rdata),
		.o_err_wr(err_wr), .o_err_rd(err_rd),
		.i_err_bvalid(err_bvalid), .i_err_rvalid(err_rvalid),
		.o_bvalid(o_bvalid), .i_bready(i_bready), .o_bresp(o_bresp),
		.o_rvalid(o_rvalid), .i_rready(i_rready), .o_r(o_r),
		.o_back_b(back_b), .o_back_r(back_r));

	axil_regs regs (
		.S_AXI_ACLK(S_AXI_ACLK), .i_reset(i_reset),
		.i_wr(reg_wr), .i_wr_idx(reg_wr_idx), .i_w(reg_w),
		.i_rd(reg_rd), .i_rd_idx(reg_rd_idx),
		.i_back_b(back_b), .i_back_r(back_r),
		.o_bvalid(reg_bvalid), .o_rvalid(reg_rvalid), .o_rdata(reg_rdata));

	axil_empty empty (
		.S_AXI_ACLK(S_AXI_ACLK), .i_reset(i_reset),
		.i_wr(err_wr), .i_rd(err_rd),
		.i_back_b(back_b), .i_back_r(back_r),
		.o_bvalid(err_bvalid), .o_rvalid(err_rvalid));

endmodule

//--- bench/axil_region_chk.sv
`timescale 1ns/1ps

module axil_region_chk (
	input logic                     S_AXI_ACLK,
	input logic                     i_reset,
	// Write response port
	input logic                     i_bvalid,
	input logic                     i_bready,
	input logic [1:0]               i_bresp,
	// Read response port
	input logic                     i_rvalid,
	input logic                     i_rready,
	input axil_region_pkg::axil_r_t i_r
);

	//////////////////////////////////////////////////
	// Response stability under back-pressure
	//////////////////////////////////////////////////

	// Stalled B keeps valid and code
	assert property (@(posedge S_AXI_ACLK) disable iff (i_reset)
		i_bvalid && !i_bready |=> i_bvalid && $stable(i_bresp))
		else $error("Write response changed before bready");

	// Stalled R keeps valid, data and code
	assert property (@(posedge S_AXI_ACLK) disable iff (i_reset)
		i_rvalid && !i_rready |=> i_rvalid && $stable(i_r))
		else $error("Read response changed before rready");

	// Reset clears both response valids
	assert property (@(posedge S_AXI_ACLK) i_reset |=> !i_bvalid && !i_rvalid)
		else $error("Response valid high right after reset");

endmodule

bind axil_region axil_region_chk chk0 (
	.S_AXI_ACLK(S_AXI_ACLK), .i_reset(i_reset),
	.i_bvalid(o_bvalid), .i_bready(i_bready), .i_bresp(o_bresp),
	.i_rvalid(o_rvalid), .i_rready(i_rready), .i_r(o_r));

//--- bench/axil_region_tb.sv
`timescale 1ns/1ps

module axil_region_tb;

	import axil_region_pkg::*;

	// One parsed trace line
	typedef struct packed {
		logic                  is_rd;
		logic [ADDR_WIDTH-1:0] addr;
		logic [DATA_WIDTH-1:0] wdata;
		logic [3:0]            strb;
		logic [1:0]            resp;
		logic [DATA_WIDTH-1:0] rdata;
	} txn_t;

	logic       S_AXI_ACLK, i_reset;
	logic       i_awvalid, o_awready, i_wvalid, o_wready, o_bvalid, i_bready;
	logic       i_arvalid, o_arready, o_rvalid, i_rready;
	logic [1:0] o_bresp;
	axil_aw_t   i_aw;
	axil_w_t    i_w;
	axil_ar_t   i_ar;
	axil_r_t    o_r;

	txn_t        trace_q[$];
	logic [31:0] rng_state;
	int          cycles, cycle_limit;
	int          resp_errs, data_errs, timing_errs, other_errs;

	axil_region dut0 (.*);

	//////////////////////////////////////////////////
	// Clock and run limit
	//////////////////////////////////////////////////

	initial begin
		S_AXI_ACLK = 1'b0;
		forever #50 S_AXI_ACLK = ~S_AXI_ACLK;
	end

	// Cycle count from reset release
	// Limit scales with the trace length
	always @(posedge S_AXI_ACLK) begin
		if (i_reset)
			cycles <= 0;
		else
			cycles <= cycles + 1;
		if (cycle_limit > 0 && cycles >= cycle_limit) begin
			$display("Run timed out after %0d cycles without finishing the trace", cycles);
			print_counts();
			$display("CHECKS FAILED");
			$finish;
		end
	end

	//////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic print_counts();
		$display("Errors: response %0d, read data %0d, timing %0d, other %0d",
			resp_errs, data_errs, timing_errs, other_errs);
	endtask

	// Lines starting with # are comments
	task automatic load_trace();
		int          fd, n;
		string       line;
		txn_t        t;
		logic [7:0]  op;
		logic [4:0]  addr;
		logic [31:0] wdata, rdata;
		logic [3:0]  strb;
		logic [1:0]  resp;
		fd = $fopen("bench/axil_region_trace.txt", "r");
		if (fd == 0) begin
			$display("Could not open the trace file bench/axil_region_trace.txt");
			other_errs++;
			return;
		end
		while ($fgets(line, fd) != 0) begin
			if (line.getc(0) == "#")
				continue;
			n = $sscanf(line, "%c %h %h %h %h %h", op, addr, wdata, strb, resp, rdata);
			if (n != 6)
				continue;
			t.is_rd = (op == "R");
			t.addr = addr;
			t.wdata = wdata;
			t.strb = strb;
			t.resp = resp;
			t.rdata = rdata;
			trace_q.push_back(t);
		end
		$fclose(fd);
	endtask

	// Present AW and W with an optional one-cycle skew and collect B under random bready
	task automatic write_txn(input txn_t t, output logic [1:0] resp);
		logic [1:0] skew;
		logic       aw_done, w_done, hs_aw, hs_w, hs_b, armed;
		aw_done = 1'b0;
		w_done = 1'b0;
		armed = 1'b0;
		rng_state = xorshift(rng_state);
		skew = rng_state[7:6];
		i_aw.addr = t.addr;
		i_w.data = t.wdata;
		i_w.strb = t.strb;
		// Skew 1 holds W back and skew 2 holds AW back
		i_awvalid = (skew != 2'd2);
		i_wvalid = (skew != 2'd1);
		forever begin
			rng_state = xorshift(rng_state);
			i_bready = (rng_state[5:4] != 2'b00);
			@(negedge S_AXI_ACLK);
			if (armed)
				assert (o_bvalid) else begin
					$display("Write response not one cycle after the request at %0t", $time);
					timing_errs++;
				end
			assert (!o_bvalid || (aw_done && w_done)) else begin
				$display("Write response showed up before the request at %0t", $time);
				other_errs++;
			end
			// A lone accepted channel sits in its skid buffer
			assert (!(aw_done && !w_done && o_awready) && !(w_done && !aw_done && o_wready))
			else begin
				$display("Request channel still ready while holding an item at %0t", $time);
				other_errs++;
			end
			hs_aw = i_awvalid && o_awready;
			hs_w = i_wvalid && o_wready;
			hs_b = o_bvalid && i_bready && aw_done && w_done;
			if (hs_b)
				resp = o_bresp;
			@(posedge S_AXI_ACLK);
			#1;
			if (hs_aw) begin
				i_awvalid = 1'b0;
				aw_done = 1'b1;
			end
			if (hs_w) begin
				i_wvalid = 1'b0;
				w_done = 1'b1;
			end
			// Late channel joins now
			if (!aw_done)
				i_awvalid = 1'b1;
			if (!w_done)
				i_wvalid = 1'b1;
			armed = (hs_aw || hs_w) && aw_done && w_done;
			if (hs_b)
				break;
		end
		i_bready = 1'b0;
		// Exactly one response per request
		@(negedge S_AXI_ACLK);
		assert (!o_bvalid) else begin
			$display("Second write response after one request at %0t", $time);
			other_errs++;
		end
		@(posedge S_AXI_ACLK);
		#1;
	endtask

	// Present AR and collect R under random rready
	task automatic read_txn(input txn_t t, output logic [1:0] resp, output logic [31:0] data);
		logic hs_ar, hs_r, ar_done, armed;
		ar_done = 1'b0;
		armed = 1'b0;
		i_ar.addr = t.addr;
		i_arvalid = 1'b1;
		forever begin
			rng_state = xorshift(rng_state);
			i_rready = (rng_state[5:4] != 2'b00);
			@(negedge S_AXI_ACLK);
			if (armed)
				assert (o_rvalid) else begin
					$display("Read response not one cycle after the request at %0t", $time);
					timing_errs++;
				end
			hs_ar = i_arvalid && o_arready;
			hs_r = o_rvalid && i_rready && ar_done;
			if (hs_r) begin
				resp = o_r.resp;
				data = o_r.data;
			end
			@(posedge S_AXI_ACLK);
			#1;
			if (hs_ar) begin
				i_arvalid = 1'b0;
				ar_done = 1'b1;
			end
			armed = hs_ar;
			if (hs_r)
				break;
		end
		i_rready = 1'b0;
		@(negedge S_AXI_ACLK);
		assert (!o_rvalid) else begin
			$display("Second read response after one request at %0t", $time);
			other_errs++;
		end
		@(posedge S_AXI_ACLK);
		#1;
	endtask

	//////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////

	initial begin
		txn_t        t;
		logic [1:0]  got_resp;
		logic [31:0] got_data;
		cycle_limit = 0;
		resp_errs = 0;
		data_errs = 0;
		timing_errs = 0;
		other_errs = 0;
		i_reset = 1'b1;
		i_awvalid = 1'b0;
		i_aw = '0;
		i_wvalid = 1'b0;
		i_w = '0;
		i_bready = 1'b0;
		i_arvalid = 1'b0;
		i_ar = '0;
		i_rready = 1'b0;
		rng_state = 32'd87322;
		load_trace();
		if (trace_q.size() == 0) begin
			$display("The trace holds no transactions");
			other_errs++;
		end
		cycle_limit = 20 * trace_q.size() + 100;
		repeat (4) @(posedge S_AXI_ACLK);
		#1 i_reset = 1'b0;
		// Buffers empty and no response pending
		@(negedge S_AXI_ACLK);
		assert (o_awready && o_wready && o_arready && !o_bvalid && !o_rvalid) else begin
			$display("Handshake outputs not in their reset state at %0t", $time);
			other_errs++;
		end
		@(posedge S_AXI_ACLK);
		#1;
		foreach (trace_q[n]) begin
			t = trace_q[n];
			if (t.is_rd) begin
				read_txn(t, got_resp, got_data);
				assert (got_resp == t.resp) else begin
					$display("ERROR %0t: o_r.resp expected %0h got %0h", $time, t.resp, got_resp);
					resp_errs++;
				end
				assert (got_data == t.rdata) else begin
					$display("ERROR %0t: o_r.data expected %h got %h", $time, t.rdata, got_data);
					data_errs++;
				end
			end else begin
				write_txn(t, got_resp);
				assert (got_resp == t.resp) else begin
					$display("ERROR %0t: o_bresp expected %0h got %0h", $time, t.resp, got_resp);
					resp_errs++;
				end
			end
		end
		repeat (2) @(posedge S_AXI_ACLK);
		print_counts();
		if (resp_errs + data_errs + timing_errs + other_errs == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

//--- bench/axil_region_trace.txt
# op addr wdata strb resp rdata, hex; op W is a write, R is a read
# resp 0 is OKAY, 3 is DECERR; rdata is checked on reads only
R 00 00000000 0 0 00000000
R 04 00000000 0 0 00000000
R 08 00000000 0 0 00000000
R 0c 00000000 0 0 00000000
W 00 12345678 f 0 00000000
R 00 00000000 0 0 12345678
W 04 cafef00d f 0 00000000
W 08 a5a5a5a5 f 0 00000000
W 0c 0badbeef f 0 00000000
R 04 00000000 0 0 cafef00d
W 04 11223344 5 0 00000000
R 04 00000000 0 0 ca22f044
W 0a 0000ff00 2 0 00000000
R 0b 00000000 0 0 a5a5ffa5
W 10 ffffffff f 3 00000000
W 14 ffffffff f 3 00000000
W 1b deadbeef f 3 00000000
W 1c ffffffff f 3 00000000
R 10 00000000 0 3 00000000
R 1c 00000000 0 3 00000000
R 00 00000000 0 0 12345678
R 04 00000000 0 0 ca22f044
R 08 00000000 0 0 a5a5ffa5
W 0c 00000000 0 0 00000000
R 0c 00000000 0 0 0badbeef

//--- axil_region.f
logic/axil_region_pkg.sv
logic/axil_skid.sv
logic/axil_route.sv
logic/axil_regs.sv
logic/axil_empty.sv
logic/axil_region.sv
bench/axil_region_chk.sv
bench/axil_region_tb.sv

//--- Makefile
TOP = axil_region_tb
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f axil_region.f

obj_dir/V$(TOP): axil_region.f $(wildcard logic/*.sv bench/*.sv)
	verilator --binary --timing --assert --top-module $(TOP) -f axil_region.f

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || echo "CHECKS FAILED" >> $(LOG)
	@cat $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
